/* flist.f */
+incdir+hdl
hdl/cpu_pkg.sv
hdl/mem_sequencer.sv
hdl/instr_decode.sv
hdl/alu_execute.sv
hdl/reg_writeback.sv
hdl/cpu_top.sv
verification/dram_model.sv
verification/tb_cpu_top.sv

/* Makefile */
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_cpu_top
RTL_TOP   ?= cpu_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

    localparam int  INSTR_CYCLES = 2 * `DRAM_WAIT_CYCLES + 5;
    localparam int  WRITE_CYCLE  = `DRAM_WAIT_CYCLES + 4;
    localparam int  TOTAL_INSTR  = 56;
    localparam real TIMEOUT_NS   = (TOTAL_INSTR * INSTR_CYCLES + 4 * (16 + 40) + 200) * 8.0;

    logic        clk = 1'b0;
    logic        rst = 1'b0;
    dram_addr_t  dram_addr;
    logic        dram_write_en;
    word_t       dram_write_data;
    word_t       dram_read_data;
    addr_t       pc;
    logic        retire;
    logic        load_en = 1'b0;
    addr_t       load_addr = '0;
    word_t       load_data = '0;
    logic        log_clear = 1'b0;

    int     errors = 0;
    int     edges = 0;
    int     prog_len;
    addr_t  pcs [$];                                     // pc seen after each retire
    addr_t  load_q_a [$];
    word_t  load_q_d [$];
    addr_t  exp_wa [$];
    word_t  exp_wd [$];

    cpu_top cpu_top_i (
        .clk, .rst, .dram_addr, .dram_write_en, .dram_write_data,
        .dram_read_data, .pc, .retire
    );

    dram_model dram_i (
        .clk, .addr(dram_addr), .write_en(dram_write_en), .write_data(dram_write_data),
        .read_data(dram_read_data), .load_en, .load_addr, .load_data, .log_clear
    );

    always #4 clk = ~clk;

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired, the DUT stopped retiring instructions");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ************************************************************************
    // Compare tasks
    // ************************************************************************

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (exp != act) begin
            errors++;
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // ************************************************************************
    // Timing monitor
    // ************************************************************************

    always @(posedge clk) begin
        edges <= rst ? edges + 1 : 0;
    end

    always @(negedge clk) begin
        int cyc;
        cyc = edges % INSTR_CYCLES + 1;                  // IDLE is cycle 1
        if (edges == 0) begin
            pcs.delete();
        end else begin
            if (retire) compare_count("retire_timing", INSTR_CYCLES, cyc);
            else if (cyc == INSTR_CYCLES) begin
                errors++;
                $display("No retire pulse at the end of instruction, cycle %0d", edges);
            end
            if (dram_write_en) compare_count("write_timing", WRITE_CYCLE, cyc);
            if (dram_addr > dram_addr_t'(`DRAM_MAP_LAST)) begin
                errors++;
                $display("DRAM address %h above the mapped range, cycle %0d", dram_addr, edges);
            end
            if (cyc == 1) pcs.push_back(pc);
        end
    end

    // ************************************************************************
    // Program building and running
    // ************************************************************************

    function automatic word_t enc(input opcode_e op, input int rd, input int rs, input int lo);
        return {op, 4'(rd), 4'(rs), 4'(lo)};
    endfunction

    function automatic word_t sext4(input int v);
        return {{12{v[3]}}, 4'(v)};
    endfunction

    function automatic word_t alu_ref(input opcode_e op, input word_t a, input word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SHL:  return a << b[3:0];
            default: return a >> b[3:0];
        endcase
    endfunction

    task automatic put(input addr_t a, input word_t d);
        load_q_a.push_back(a);
        load_q_d.push_back(d);
    endtask

    task automatic emit(input word_t w);
        put(addr_t'(prog_len), w);
        prog_len++;
    endtask

    task automatic start_program();
        prog_len = 0;
        exp_wa.delete();
        exp_wd.delete();
    endtask

    // Reset, load the program while in reset, run n instructions, check writes
    task automatic run_program(input string name, input int n);
        @(negedge clk);
        rst       = 1'b0;
        log_clear = 1'b1;
        while (load_q_a.size() > 0) begin
            load_en   = 1'b1;
            load_addr = load_q_a.pop_front();
            load_data = load_q_d.pop_front();
            @(negedge clk);
        end
        load_en = 1'b0;
        repeat (16) @(negedge clk);
        log_clear = 1'b0;
        rst       = 1'b1;
        while (pcs.size() < n) @(posedge clk);
        @(negedge clk);
        compare_count({name, "_writes"}, exp_wa.size(), dram_i.wr_count);
        for (int i = 0; i < exp_wa.size() && i < dram_i.wr_count; i++) begin
            compare_addr({name, "_waddr"}, exp_wa[i], dram_i.wr_addr[i]);
            compare_word({name, "_wdata"}, exp_wd[i], dram_i.wr_data[i]);
        end
    endtask

    // ************************************************************************
    // Directed tests
    // ************************************************************************

    task automatic test_alu();
        opcode_e ops [7] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR};
        word_t   a;
        word_t   b;
        a = word_t'($urandom);
        b = word_t'($urandom);
        start_program();
        put(16'h0080, a);
        put(16'h0081, b);
        emit(enc(OP_LDI, 1, 8, 0));
        emit(enc(OP_LDI, 2, 8, 1));
        emit(enc(OP_LD, 3, 1, 0));
        emit(enc(OP_LD, 4, 2, 0));
        emit(enc(OP_LDI, 5, 12, 0));                     // Result area at 0x00C0
        for (int i = 0; i < 7; i++) begin
            emit(enc(ops[i], 7, 3, 4));
            emit(enc(OP_ST, 0, 5, 7));
            emit(enc(OP_ADDI, 5, 5, 1));
            exp_wa.push_back(addr_t'(16'h00c0 + i));
            exp_wd.push_back(alu_ref(ops[i], a, b));
        end
        run_program("alu", prog_len);
    endtask

    task automatic test_immediates();
        start_program();
        emit(enc(OP_LDI, 1, 4, 0));
        emit(enc(OP_LDI, 2, 3, 7));
        emit(enc(OP_ADDI, 3, 2, 13));                    // -3
        emit(enc(OP_ST, 0, 1, 3));
        emit(enc(OP_ADDI, 1, 1, 1));
        emit(enc(OP_ADDI, 3, 2, 7));
        emit(enc(OP_ST, 0, 1, 3));
        emit(enc(OP_ADDI, 1, 1, 1));
        emit(enc(OP_LDI, 4, 15, 0));
        emit(enc(OP_ADDI, 5, 4, 8));                     // -8
        emit(enc(OP_ST, 0, 1, 5));
        exp_wa = '{16'h0040, 16'h0041, 16'h0042};
        exp_wd = '{16'h0037 + sext4(13), 16'h0037 + sext4(7), 16'h00f0 + sext4(8)};
        run_program("imm", prog_len);
    endtask

    task automatic test_branch();
        addr_t exp_pc [9] = '{1, 2, 3, 4, 6, 7, 8, 9, 10};
        start_program();
        emit(enc(OP_LDI, 1, 4, 0));
        emit(enc(OP_LDI, 5, 1, 1));                      // Marker 0x11
        emit(enc(OP_LDI, 6, 2, 2));                      // Marker 0x22
        emit(enc(OP_LDI, 3, 0, 1));
        emit(enc(OP_BRZ, 0, 0, 1));                      // Taken, skips the next store
        emit(enc(OP_ST, 0, 1, 5));
        emit(enc(OP_BRZ, 3, 0, 1));                      // Not taken
        emit(enc(OP_ST, 0, 1, 6));
        emit(enc(OP_ADDI, 1, 1, 1));
        emit(enc(OP_ST, 0, 1, 5));
        exp_wa = '{16'h0040, 16'h0041};
        exp_wd = '{16'h0022, 16'h0011};
        run_program("branch", 9);
        for (int i = 0; i < 9; i++) begin
            compare_addr("branch_pc", exp_pc[i], pcs[i]);
        end
    endtask

    task automatic test_memory_map();
        word_t first;
        start_program();
        first = enc(OP_LDI, 1, 15, 8);
        emit(first);
        emit(enc(OP_LDI, 2, 0, 8));
        emit(enc(OP_SHL, 1, 1, 2));                      // r1 = 0xF800
        emit(enc(OP_LDI, 3, 5, 12));
        emit(enc(OP_ST, 0, 1, 3));                       // Dropped
        emit(enc(OP_LDI, 5, 0, 1));
        emit(enc(OP_SUB, 4, 0, 5));                      // r4 = 0xFFFF
        emit(enc(OP_LD, 6, 4, 0));
        emit(enc(OP_LDI, 7, 5, 0));
        emit(enc(OP_ST, 0, 7, 6));
        exp_wa = '{16'h0050};
        exp_wd = '{first};
        run_program("map", prog_len);
    endtask

    initial begin
        void'($urandom(32'hc566));
        repeat (16) @(negedge clk);
        test_alu();
        test_immediates();
        test_branch();
        test_memory_map();
        $display("Tests done with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/dram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_model import cpu_pkg::*; (
    input  wire         clk,
    input  dram_addr_t  addr,
    input  wire         write_en,
    input  word_t       write_data,
    output word_t       read_data,
    input  wire         load_en,
    input  addr_t       load_addr,
    input  word_t       load_data,
    input  wire         log_clear
);

    word_t  mem [65536];
    word_t  rd_pipe [2];
    addr_t  wr_addr [64];                                // Write log, read by the testbench
    word_t  wr_data [64];
    int     wr_count;

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = word_t'(i) ^ {word_t'(i) << 5} ^ 16'ha5c3;
        end
        wr_count  = 0;
        read_data = '0;
    end

    // Read data settles three cycles after the address
    always @(posedge clk) begin
        rd_pipe[0] <= mem[addr[15:0]];
        rd_pipe[1] <= rd_pipe[0];
        read_data  <= rd_pipe[1];
        if (load_en) mem[load_addr] <= load_data;
        if (log_clear) begin
            wr_count <= 0;
        end else if (write_en) begin
            mem[addr[15:0]]   <= write_data;
            wr_addr[wr_count] <= addr_t'(addr[15:0]);
            wr_data[wr_count] <= write_data;
            wr_count          <= wr_count + 1;
        end
    end

endmodule

`default_nettype wire

/* hdl/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    output dram_addr_t  dram_addr,
    output logic        dram_write_en,
    output word_t       dram_write_data,
    input  word_t       dram_read_data,
    output addr_t       pc,
    output logic        retire
);

    word_t     instr;
    logic      instr_valid;
    word_t     load_data;
    opcode_e   opcode;
    reg_idx_t  rd;
    reg_idx_t  rs;
    reg_idx_t  rt;
    word_t     imm4_sext;
    word_t     imm8;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    logic      reg_write;
    word_t     rs_data;
    word_t     rt_data;
    word_t     rd_data;
    word_t     alu_result;
    addr_t     data_addr;
    word_t     store_data;
    logic      branch_taken;

    mem_sequencer mem_sequencer_i (
        .clk, .rst, .pc, .data_addr, .store_data, .is_store, .dram_read_data,
        .dram_addr, .dram_write_en, .dram_write_data,
        .instr, .instr_valid, .load_data, .retire
    );

    instr_decode instr_decode_i (
        .instr, .instr_valid, .opcode, .rd, .rs, .rt, .imm4_sext, .imm8,
        .is_load, .is_store, .is_branch, .reg_write
    );

    alu_execute alu_execute_i (
        .opcode, .imm4_sext, .imm8, .rs_data, .rt_data, .rd_data, .is_branch,
        .alu_result, .data_addr, .store_data, .branch_taken
    );

    reg_writeback reg_writeback_i (
        .clk, .rst, .rs, .rt, .rd, .reg_write, .is_load, .retire,
        .load_data, .alu_result, .imm8, .branch_taken,
        .rs_data, .rt_data, .rd_data, .pc
    );

endmodule

`default_nettype wire

/* hdl/reg_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_writeback import cpu_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  reg_idx_t  rs,
    input  reg_idx_t  rt,
    input  reg_idx_t  rd,
    input  wire       reg_write,
    input  wire       is_load,
    input  wire       retire,
    input  word_t     load_data,
    input  word_t     alu_result,
    input  word_t     imm8,
    input  wire       branch_taken,
    output word_t     rs_data,
    output word_t     rt_data,
    output word_t     rd_data,
    output addr_t     pc
);

    word_t  regs [16];
    addr_t  pc_plus_one;

    assign rs_data = regs[rs];
    assign rt_data = regs[rt];
    assign rd_data = regs[rd];

    assign pc_plus_one = pc + 1'b1;

    // Registers and PC only move when an instruction retires
    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= '0;
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (retire) begin
            if (reg_write) regs[rd] <= is_load ? load_data : alu_result;
            pc <= branch_taken ? pc_plus_one + addr_t'(imm8) : pc_plus_one;
        end
    end

endmodule

`default_nettype wire

/* hdl/alu_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_execute import cpu_pkg::*; (
    input  opcode_e  opcode,
    input  word_t    imm4_sext,
    input  word_t    imm8,
    input  word_t    rs_data,
    input  word_t    rt_data,
    input  word_t    rd_data,
    input  wire      is_branch,
    output word_t    alu_result,
    output addr_t    data_addr,
    output word_t    store_data,
    output logic     branch_taken
);

    logic [3:0] shamt;

    assign shamt = rt_data[3:0];                         // Shift by low 4 bits of rt

    // ************************************************************************
    // ALU
    // ************************************************************************

    always_comb begin
        case (opcode)
            OP_ADD:  alu_result = rs_data + rt_data;
            OP_SUB:  alu_result = rs_data - rt_data;
            OP_AND:  alu_result = rs_data & rt_data;
            OP_OR:   alu_result = rs_data | rt_data;
            OP_XOR:  alu_result = rs_data ^ rt_data;
            OP_SHL:  alu_result = rs_data << shamt;
            OP_SHR:  alu_result = rs_data >> shamt;
            OP_ADDI: alu_result = rs_data + imm4_sext;
            OP_LDI:  alu_result = imm8;                  // Zero-extended by decode
            default: alu_result = '0;                    // LD, ST, BRZ
        endcase
    end

    // ************************************************************************
    // Memory access and branch
    // ************************************************************************

    // Address of LD and ST, unused data read for everything else
    assign data_addr  = addr_t'(rs_data);
    assign store_data = rt_data;

    assign branch_taken = is_branch && (rd_data == '0);

endmodule

`default_nettype wire

/* hdl/instr_decode.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"
`default_nettype none

module instr_decode import cpu_pkg::*; (
    input  word_t     instr,
    input  wire       instr_valid,
    output opcode_e   opcode,
    output reg_idx_t  rd,
    output reg_idx_t  rs,
    output reg_idx_t  rt,
    output word_t     imm4_sext,
    output word_t     imm8,
    output logic      is_load,
    output logic      is_store,
    output logic      is_branch,
    output logic      reg_write
);

    logic writes_rd;

    // ************************************************************************
    // Field split
    // ************************************************************************

    assign opcode = opcode_e'(instr[15:12]);
    assign rd     = instr[11:8];
    assign rs     = instr[7:4];
    assign rt     = instr[3:0];

    assign imm4_sext = {{(`CPU_WORD_WIDTH-4){instr[3]}}, instr[3:0]};

    // Branch offset is signed, the LDI constant is not
    assign imm8 = (opcode == OP_BRZ) ? {{(`CPU_WORD_WIDTH-8){instr[7]}}, instr[7:0]}
                                     : {{(`CPU_WORD_WIDTH-8){1'b0}}, instr[7:0]};

    // ************************************************************************
    // Class flags
    // ************************************************************************

    always_comb begin
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_SHL, OP_SHR, OP_ADDI, OP_LDI, OP_LD: writes_rd = 1'b1;
            default:                                writes_rd = 1'b0;  // ST, BRZ, unused
        endcase
    end

    // Stale instruction word must not trigger anything
    assign is_load   = instr_valid && (opcode == OP_LD);
    assign is_store  = instr_valid && (opcode == OP_ST);
    assign is_branch = instr_valid && (opcode == OP_BRZ);
    assign reg_write = instr_valid && writes_rd;

endmodule

`default_nettype wire

/* hdl/mem_sequencer.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"
`default_nettype none

module mem_sequencer import cpu_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  addr_t       pc,
    input  addr_t       data_addr,
    input  word_t       store_data,
    input  wire         is_store,
    input  word_t       dram_read_data,
    output dram_addr_t  dram_addr,
    output logic        dram_write_en,
    output word_t       dram_write_data,
    output word_t       instr,
    output logic        instr_valid,
    output word_t       load_data,
    output logic        retire
);

    localparam int WAIT_W = $clog2(`DRAM_WAIT_CYCLES + 1);

    seq_state_e          state;
    logic [WAIT_W-1:0]   wait_count;
    logic                wait_last;

    function automatic logic in_map(input addr_t addr);
        return addr <= addr_t'(`DRAM_MAP_LAST);
    endfunction

    // Out-of-map addresses land on DRAM word 0
    function automatic dram_addr_t map_addr(input addr_t addr);
        return in_map(addr) ? dram_addr_t'(addr) : '0;
    endfunction

    assign wait_last = (wait_count == WAIT_W'(`DRAM_WAIT_CYCLES - 1));

    // ************************************************************************
    // Sequencer FSM, one instruction per pass
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (!rst) begin
            state         <= IDLE;
            wait_count    <= '0;
            dram_addr     <= '0;
            dram_write_en <= 1'b0;
        end else begin
            dram_write_en <= 1'b0;                       // Pulse lasts FETCH_DATA only
            case (state)
                IDLE: begin
                    dram_addr <= map_addr(pc);
                    state     <= FETCH_INSTR;
                end
                FETCH_INSTR: begin
                    wait_count <= '0;
                    state      <= WAIT_INSTR;
                end
                WAIT_INSTR: begin
                    wait_count <= wait_count + 1'b1;
                    if (wait_last) state <= INSTR_OUT;
                end
                INSTR_OUT: begin
                    // Decode and execute already see the new instruction here
                    dram_addr     <= map_addr(data_addr);
                    dram_write_en <= is_store && in_map(data_addr);
                    state         <= FETCH_DATA;
                end
                FETCH_DATA: begin
                    wait_count <= '0;
                    state      <= WAIT_DATA;
                end
                WAIT_DATA: begin
                    wait_count <= wait_count + 1'b1;
                    if (wait_last) state <= DATA_OUT;
                end
                DATA_OUT: state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (state == WAIT_INSTR && wait_last) instr <= dram_read_data;
        if (state == WAIT_DATA && wait_last) load_data <= dram_read_data;
        if (state == INSTR_OUT) dram_write_data <= store_data;
    end

    assign instr_valid = (state == INSTR_OUT) || (state == FETCH_DATA) ||
                         (state == WAIT_DATA) || (state == DATA_OUT);
    assign retire      = (state == DATA_OUT);

endmodule

`default_nettype wire

/* hdl/cpu_pkg.sv */
`include "cpu_defs.svh"
`default_nettype none

package cpu_pkg;

    typedef logic [`CPU_WORD_WIDTH-1:0]  word_t;
    typedef logic [`CPU_WORD_WIDTH-1:0]  addr_t;
    typedef logic [`DRAM_ADDR_WIDTH-1:0] dram_addr_t;
    typedef logic [3:0]                  reg_idx_t;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SHL  = 4'd5,
        OP_SHR  = 4'd6,
        OP_ADDI = 4'd7,
        OP_LDI  = 4'd8,
        OP_LD   = 4'd9,
        OP_ST   = 4'd10,
        OP_BRZ  = 4'd11
    } opcode_e;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_INSTR,
        WAIT_INSTR,
        INSTR_OUT,
        FETCH_DATA,
        WAIT_DATA,
        DATA_OUT
    } seq_state_e;

endpackage

`default_nettype wire

/* hdl/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`default_nettype none

// ****************************************************************************
// Word and address widths
// ****************************************************************************

`define CPU_WORD_WIDTH   16        // Data, instruction and CPU address width
`define DRAM_ADDR_WIDTH  25        // DRAM word address width

// ****************************************************************************
// Memory map and DRAM timing
// ****************************************************************************

// Highest CPU address that reaches the DRAM, anything above goes to word 0
`define DRAM_MAP_LAST    16'hF7FF

// Wait cycles after each DRAM address, must cover the DRAM read latency
`define DRAM_WAIT_CYCLES 12

`default_nettype wire

`endif
